// ==== rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN      = 32;
  localparam int NUM_REGS  = 32;
  localparam int REG_IDX_W = 5;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  localparam word_t PC_STEP = 32'd4;

  // Major opcodes kept by this core
  typedef enum logic [6:0] {
    OP_LUI      = 7'b0110111,
    OP_AUIPC    = 7'b0010111,
    OP_IMM      = 7'b0010011,
    OP_REG      = 7'b0110011,
    OP_BRANCH   = 7'b1100011,
    OP_JAL      = 7'b1101111,
    OP_JALR     = 7'b1100111,
    OP_MISC_MEM = 7'b0001111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // funct7 selects SUB and SRA when bit 5 is set
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  // ALU funct3 codes
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Branch funct3 codes
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef struct packed {
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic       we;
    alu_op_e    alu_op;
    logic       a_is_pc;
    logic       b_is_imm;
    logic       branch;
    logic [2:0] br_funct3;
    logic       jal;
    logic       jalr;
    logic       link;
    logic       halt;
    word_t      imm;
  } ctrl_t;

  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    data;
  } retire_t;

endpackage

// ==== rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::word_t i_insn,
  output rv_pkg::ctrl_t o_ctrl
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_b;
  word_t      imm_j;
  logic       funct7_alt;
  logic       funct7_base;

  // Shared funct3 to ALU mapping for reg-imm and reg-reg
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode      = opcode_e'(i_insn[6:0]);
  assign funct7      = i_insn[31:25];
  assign funct3      = i_insn[14:12];
  assign funct7_alt  = (funct7 == FUNCT7_ALT);
  assign funct7_base = (funct7 == FUNCT7_BASE);

  // Immediates, all sign-extended from bit 31
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_u = {i_insn[31:12], 12'b0};
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
                  i_insn[30:21], 1'b0};

  always_comb begin
    o_ctrl           = '0;
    o_ctrl.rs1       = i_insn[19:15];
    o_ctrl.rs2       = i_insn[24:20];
    o_ctrl.rd        = i_insn[11:7];
    o_ctrl.alu_op    = ALU_ADD;
    o_ctrl.br_funct3 = funct3;
    o_ctrl.imm       = imm_i;

    case (opcode)
      OP_LUI: begin
        o_ctrl.we       = 1'b1;
        o_ctrl.alu_op   = ALU_PASS_B;
        o_ctrl.b_is_imm = 1'b1;
        o_ctrl.imm      = imm_u;
      end
      OP_AUIPC: begin
        o_ctrl.we       = 1'b1;
        o_ctrl.a_is_pc  = 1'b1;
        o_ctrl.b_is_imm = 1'b1;
        o_ctrl.imm      = imm_u;
      end
      OP_IMM: begin
        o_ctrl.b_is_imm = 1'b1;
        // Only the shifts look at funct7
        o_ctrl.alu_op   = alu_from_funct3(funct3, (funct3 == F3_SR) && funct7_alt);
        if (funct3 == F3_SLL) begin
          o_ctrl.we = funct7_base;
        end else if (funct3 == F3_SR) begin
          o_ctrl.we = funct7_base || funct7_alt;
        end else begin
          o_ctrl.we = 1'b1;
        end
      end
      OP_REG: begin
        o_ctrl.alu_op = alu_from_funct3(funct3, funct7_alt);
        o_ctrl.we     = funct7_base || (funct7_alt && (funct3 == F3_ADD || funct3 == F3_SR));
      end
      OP_BRANCH: begin
        o_ctrl.imm    = imm_b;
        // Compare mode follows funct3 bit 1 (unsigned for bltu and bgeu)
        o_ctrl.alu_op = funct3[1] ? ALU_SLTU : ALU_SLT;
        o_ctrl.branch = (funct3 != F3_SLT) && (funct3 != F3_SLTU);
      end
      OP_JAL: begin
        o_ctrl.we   = 1'b1;
        o_ctrl.jal  = 1'b1;
        o_ctrl.link = 1'b1;
        o_ctrl.imm  = imm_j;
      end
      OP_JALR: begin
        if (funct3 == 3'b000) begin
          o_ctrl.we   = 1'b1;
          o_ctrl.jalr = 1'b1;
          o_ctrl.link = 1'b1;
        end
      end
      OP_MISC_MEM: begin
        // FENCE retires as a no-op
        o_ctrl.we = 1'b0;
      end
      OP_SYSTEM: begin
        o_ctrl.halt = (i_insn[31:7] == 25'd0);
      end
      default: begin
        o_ctrl.we = 1'b0;
      end
    endcase

    // x0 is never written, so the retire record shows no write
    if (o_ctrl.rd == '0) begin
      o_ctrl.we = 1'b0;
    end
  end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t i_rs1,
  input  rv_pkg::reg_idx_t i_rs2,
  input  rv_pkg::retire_t  i_wr,
  output rv_pkg::word_t    o_rs1_data,
  output rv_pkg::word_t    o_rs2_data
);
  import rv_pkg::*;

  // Only x1..x31 have storage
  word_t regs [1:NUM_REGS-1];

  // Combinational reads where x0 reads as zero
  always_comb begin
    if (i_rs1 == '0) begin
      o_rs1_data = '0;
    end else begin
      o_rs1_data = regs[i_rs1];
    end
    if (i_rs2 == '0) begin
      o_rs2_data = '0;
    end else begin
      o_rs2_data = regs[i_rs2];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.we && (i_wr.rd != '0)) begin
      regs[i_wr.rd] <= i_wr.data;
    end
  end

endmodule

// ==== rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_e i_op,
  input  rv_pkg::word_t   i_a,
  input  rv_pkg::word_t   i_b,
  output rv_pkg::word_t   o_result,
  output logic            o_lt,
  output logic            o_eq
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  word_t      sum;
  word_t      diff;

  assign shamt       = i_b[4:0];
  assign sum         = i_a + i_b;
  assign diff        = i_a - i_b;
  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  // Compare outputs feed the branch decision
  assign o_lt = (i_op == ALU_SLTU) ? lt_unsigned : lt_signed;
  assign o_eq = (i_a == i_b);

  always_comb begin
    case (i_op)
      ALU_ADD: begin
        o_result = sum;
      end
      ALU_SUB: begin
        o_result = diff;
      end
      ALU_SLL: begin
        o_result = i_a << shamt;
      end
      ALU_SLT: begin
        o_result = {{(XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
      end
      ALU_XOR: begin
        o_result = i_a ^ i_b;
      end
      ALU_SRL: begin
        o_result = i_a >> shamt;
      end
      ALU_SRA: begin
        o_result = word_t'($signed(i_a) >>> shamt);
      end
      ALU_OR: begin
        o_result = i_a | i_b;
      end
      ALU_AND: begin
        o_result = i_a & i_b;
      end
      default: begin
        // LUI passes the U immediate straight through
        o_result = i_b;
      end
    endcase
  end

endmodule

// ==== rv_pc_unit.sv ====
`timescale 1ns/1ps

module rv_pc_unit (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::ctrl_t i_ctrl,
  input  rv_pkg::word_t i_rs1_data,
  input  logic          i_lt,
  input  logic          i_eq,
  output rv_pkg::word_t o_pc,
  output rv_pkg::word_t o_link,
  output logic          o_halt
);
  import rv_pkg::*;

  word_t pc_q;
  word_t pc_next;
  word_t pc_plus_imm;
  word_t jalr_sum;
  logic  br_taken;

  assign o_pc        = pc_q;
  assign o_link      = pc_q + PC_STEP;
  assign o_halt      = i_ctrl.halt;
  assign pc_plus_imm = pc_q + i_ctrl.imm;
  assign jalr_sum    = i_rs1_data + i_ctrl.imm;

  always_comb begin
    case (i_ctrl.br_funct3)
      F3_BEQ:  br_taken = i_eq;
      F3_BNE:  br_taken = !i_eq;
      F3_BLT:  br_taken = i_lt;
      F3_BGE:  br_taken = !i_lt;
      F3_BLTU: br_taken = i_lt;
      F3_BGEU: br_taken = !i_lt;
      default: br_taken = 1'b0;
    endcase
  end

  // Halt holds the PC so ECALL keeps being presented
  always_comb begin
    if (i_ctrl.halt) begin
      pc_next = pc_q;
    end else if (i_ctrl.jal) begin
      pc_next = pc_plus_imm;
    end else if (i_ctrl.jalr) begin
      pc_next = {jalr_sum[XLEN-1:1], 1'b0};
    end else if (i_ctrl.branch && br_taken) begin
      pc_next = pc_plus_imm;
    end else begin
      pc_next = o_link;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::word_t   i_insn,
  output rv_pkg::word_t   o_pc,
  output rv_pkg::retire_t o_retire,
  output logic            o_halt
);
  import rv_pkg::*;

  ctrl_t   ctrl;
  word_t   rs1_data;
  word_t   rs2_data;
  word_t   alu_a;
  word_t   alu_b;
  word_t   alu_result;
  word_t   link;
  logic    alu_lt;
  logic    alu_eq;
  retire_t retire;

  rv_decoder u_decoder (
    .i_insn (i_insn),
    .o_ctrl (ctrl)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (ctrl.rs1),
    .i_rs2      (ctrl.rs2),
    .i_wr       (retire),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // Operand muxes select the PC for AUIPC and the immediate for I and U forms
  assign alu_a = ctrl.a_is_pc ? o_pc : rs1_data;
  assign alu_b = ctrl.b_is_imm ? ctrl.imm : rs2_data;

  rv_alu u_alu (
    .i_op     (ctrl.alu_op),
    .i_a      (alu_a),
    .i_b      (alu_b),
    .o_result (alu_result),
    .o_lt     (alu_lt),
    .o_eq     (alu_eq)
  );

  rv_pc_unit u_pc_unit (
    .clk        (clk),
    .rst        (rst),
    .i_ctrl     (ctrl),
    .i_rs1_data (rs1_data),
    .i_lt       (alu_lt),
    .i_eq       (alu_eq),
    .o_pc       (o_pc),
    .o_link     (link),
    .o_halt     (o_halt)
  );

  // Jumps write the return address and everything else the ALU result
  assign retire.we   = ctrl.we;
  assign retire.rd   = ctrl.rd;
  assign retire.data = ctrl.link ? link : alu_result;

  assign o_retire = retire;

endmodule

// ==== rv_core_props.sv ====
`timescale 1ns/1ps

module rv_core_props (
  input logic            clk,
  input logic            rst,
  input rv_pkg::word_t   i_pc,
  input rv_pkg::retire_t i_retire,
  input logic            i_halt
);

  // x0 must keep reading zero
  a_no_x0_value: assert property (@(posedge clk) disable iff (rst)
    !(i_retire.we && (i_retire.rd == '0) && (i_retire.data != '0)))
    else $error("retire record writes a non-zero value to x0");

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) i_pc[1:0] == 2'b00)
    else $error("PC is not word aligned");

  // ECALL is re-presented, so the PC may not move
  a_halt_holds_pc: assert property (@(posedge clk) disable iff (rst) i_halt |=> $stable(i_pc))
    else $error("PC moved while the core was halted");

endmodule

bind rv_core rv_core_props u_props (
  .clk      (clk),
  .rst      (rst),
  .i_pc     (o_pc),
  .i_retire (o_retire),
  .i_halt   (o_halt)
);

// ==== rv_checker.sv ====
`timescale 1ns/1ps

module rv_checker (
  input  logic            clk,
  input  logic            rst,
  input  int              i_test_id,
  input  rv_pkg::word_t   i_pc,
  input  rv_pkg::word_t   i_insn,
  input  rv_pkg::retire_t i_retire,
  input  logic            i_halt,
  output int              o_passed,
  output int              o_failed,
  output int              o_errors
);
  import rv_pkg::*;

  // ECALL cycle plus five held cycles
  localparam int HOLD_CYCLES = 6;

  word_t   regs [NUM_REGS];
  word_t   ref_pc;
  retire_t exp_ret;
  word_t   exp_next;
  logic    exp_halt;
  int      test_errs;
  int      halt_cycles;
  int      passed = 0;
  int      failed = 0;
  int      errors = 0;

  assign o_passed = passed;
  assign o_failed = failed;
  assign o_errors = errors;

  function automatic string test_name(input int id);
    case (id)
      1: return "reg_imm";
      2: return "reg_reg";
      3: return "x0_write";
      4: return "branches";
      5: return "jumps_auipc";
      6: return "ecall_halt";
      default: return "unknown";
    endcase
  endfunction

  // Integer result of one OP or OP-IMM operation
  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                    input word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // One architectural step against the model registers
  function automatic void step_ref(input word_t pc, input word_t insn, output retire_t ret,
                                   output word_t next, output logic halt);
    word_t      rs1_v;
    word_t      rs2_v;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_j;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       taken;
    rs1_v = regs[insn[19:15]];
    rs2_v = regs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    f3 = insn[14:12];
    f7 = insn[31:25];
    ret = '0;
    ret.rd = insn[11:7];
    next = pc + PC_STEP;
    halt = 1'b0;
    taken = 1'b0;
    case (insn[6:0])
      OP_LUI: begin
        ret.we = 1'b1;
        ret.data = {insn[31:12], 12'd0};
      end
      OP_AUIPC: begin
        ret.we = 1'b1;
        ret.data = pc + {insn[31:12], 12'd0};
      end
      OP_IMM: begin
        // Shift immediates carry funct7 in their upper bits
        ret.we = (f3 == 3'd1) ? (f7 == 7'h00) : ((f3 != 3'd5) || (f7 == 7'h00) || (f7 == 7'h20));
        ret.data = alu_ref(f3, (f3 == 3'd5) && (f7 == 7'h20), rs1_v, imm_i);
      end
      OP_REG: begin
        ret.we = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        ret.data = alu_ref(f3, f7 == 7'h20, rs1_v, rs2_v);
      end
      OP_BRANCH: begin
        case (f3)
          3'd0: taken = (rs1_v == rs2_v);
          3'd1: taken = (rs1_v != rs2_v);
          3'd4: taken = ($signed(rs1_v) < $signed(rs2_v));
          3'd5: taken = ($signed(rs1_v) >= $signed(rs2_v));
          3'd6: taken = (rs1_v < rs2_v);
          3'd7: taken = (rs1_v >= rs2_v);
          default: taken = 1'b0;
        endcase
        if (taken) begin
          next = pc + imm_b;
        end
      end
      OP_JAL: begin
        ret.we = 1'b1;
        ret.data = pc + PC_STEP;
        next = pc + imm_j;
      end
      OP_JALR: begin
        if (f3 == 3'd0) begin
          ret.we = 1'b1;
          ret.data = pc + PC_STEP;
          next = (rs1_v + imm_i) & ~32'd1;
        end
      end
      OP_SYSTEM: begin
        if (insn[31:7] == 25'd0) begin
          halt = 1'b1;
          next = pc;
        end
      end
      default: begin
        ret.we = 1'b0;
      end
    endcase
    if (ret.rd == 5'd0) begin
      ret.we = 1'b0;
    end
  endfunction

  task automatic check_value(input string what, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("error %s %s: expected %h actual %h", test_name(i_test_id), what, exp, act);
      test_errs++;
      errors++;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] = '0;
      end
      ref_pc = '0;
      test_errs = 0;
      halt_cycles = 0;
    end else begin
      step_ref(ref_pc, i_insn, exp_ret, exp_next, exp_halt);
      check_value("pc", ref_pc, i_pc);
      check_value("halt", word_t'(exp_halt), word_t'(i_halt));
      check_value("retire we", word_t'(exp_ret.we), word_t'(i_retire.we));
      if (exp_ret.we) begin
        check_value("retire rd", word_t'(exp_ret.rd), word_t'(i_retire.rd));
        check_value("retire data", exp_ret.data, i_retire.data);
        regs[exp_ret.rd] = exp_ret.data;
      end
      ref_pc = exp_next;
      if (exp_halt) begin
        halt_cycles++;
      end else begin
        halt_cycles = 0;
      end
      if (halt_cycles == HOLD_CYCLES) begin
        if (test_errs == 0) begin
          passed++;
          $display("test %s passed", test_name(i_test_id));
        end else begin
          failed++;
          $display("test %s failed with %0d mismatches", test_name(i_test_id), test_errs);
        end
      end
    end
  end

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  localparam word_t ECALL     = 32'h0000_0073;
  localparam int    MEM_WORDS = 256;
  localparam int    NUM_TESTS = 6;

  logic    clk = 1'b0;
  logic    rst = 1'b1;
  word_t   insn = ECALL;
  word_t   pc;
  retire_t retire;
  logic    halt;
  word_t   imem [MEM_WORDS];
  int      prog_len = 0;
  int      test_id = 0;
  int      seed = 32'hd616_ddcb;
  int      budget = 8;
  int      cycles = 0;
  int      passed;
  int      failed;
  int      errors;

  always #2 clk = ~clk;

  rv_core i_dut (
    .clk      (clk),
    .rst      (rst),
    .i_insn   (insn),
    .o_pc     (pc),
    .o_retire (retire),
    .o_halt   (halt)
  );

  rv_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .i_test_id (test_id),
    .i_pc      (pc),
    .i_insn    (insn),
    .i_retire  (retire),
    .i_halt    (halt),
    .o_passed  (passed),
    .o_failed  (failed),
    .o_errors  (errors)
  );

  // Instruction memory where addresses past the array read as ECALL
  always @(negedge clk) begin
    if (pc[31:10] == '0) begin
      insn <= imem[pc[9:2]];
    end else begin
      insn <= ECALL;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > budget) begin
      $display("timeout: core did not halt within %0d cycles", budget);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic word_t encode_i(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd, input opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t encode_r(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t encode_u(input logic [19:0] imm, input reg_idx_t rd, input opcode_e op);
    return {imm, rd, op};
  endfunction

  function automatic word_t encode_b(input logic [12:0] off, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic word_t encode_j(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  task automatic emit(input word_t word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic begin_test(input int id);
    @(negedge clk);
    rst = 1'b1;
    test_id = id;
    prog_len = 0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      imem[a] = ECALL;
    end
  endtask

  // Ends the program with ECALL, releases reset and waits out the halt
  task automatic run_program();
    emit(ECALL);
    budget += prog_len * 4 + 20;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    while (!halt) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk);
  endtask

  task automatic seed_regs();
    word_t r;
    for (int i = 1; i <= 8; i++) begin
      r = $random(seed);
      emit(encode_u(r[31:12], reg_idx_t'(i), OP_LUI));
      emit(encode_i(r[11:0], reg_idx_t'(i), 3'd0, reg_idx_t'(i), OP_IMM));
    end
  endtask

  task automatic random_reg_imm(input int count);
    word_t       r;
    logic [11:0] imm;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      imm = r[31:20];
      // Shifts need a legal funct7 above the shift amount
      if (r[14:12] == 3'd1) begin
        imm = {7'd0, r[24:20]};
      end else if (r[14:12] == 3'd5) begin
        imm = {1'b0, r[30], 5'd0, r[24:20]};
      end
      emit(encode_i(imm, {1'b0, r[18:15]}, r[14:12], {1'b0, r[10:7]}, OP_IMM));
    end
  endtask

  task automatic random_reg_reg(input int count);
    word_t      r;
    logic [6:0] f7;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      f7 = FUNCT7_BASE;
      if (r[30] && ((r[14:12] == 3'd0) || (r[14:12] == 3'd5))) begin
        f7 = FUNCT7_ALT;
      end
      emit(encode_r(f7, {1'b0, r[23:20]}, {1'b0, r[18:15]}, r[14:12], {1'b0, r[10:7]}));
    end
  endtask

  task automatic branch_program();
    logic [2:0] br_f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    emit(encode_i(12'd5, 5'd0, 3'd0, 5'd1, OP_IMM));
    emit(encode_i(12'hffd, 5'd0, 3'd0, 5'd2, OP_IMM));
    // Operand pairs (x1,x2) (x2,x1) (x1,x1) give taken and not taken
    for (int b = 0; b < 6; b++) begin
      for (int p = 0; p < 3; p++) begin
        emit(encode_b(13'd8, (p == 0) ? 5'd2 : 5'd1, (p == 1) ? 5'd2 : 5'd1, br_f3[b]));
        emit(encode_i(12'd1, 5'd3, 3'd0, 5'd3, OP_IMM));
      end
    end
  endtask

  task automatic jump_program();
    emit(encode_u(20'h12345, 5'd4, OP_AUIPC));
    emit(encode_j(21'd8, 5'd5));
    emit(encode_i(12'd1, 5'd0, 3'd0, 5'd9, OP_IMM));
    emit(encode_i(12'd25, 5'd0, 3'd0, 5'd6, OP_IMM));
    // Odd target whose bit 0 is dropped
    emit(encode_i(12'd0, 5'd6, 3'd0, 5'd7, OP_JALR));
    emit(encode_i(12'd2, 5'd0, 3'd0, 5'd9, OP_IMM));
    emit(encode_u(20'h00001, 5'd8, OP_AUIPC));
    emit(encode_j(21'd8, 5'd10));
    emit(encode_j(21'd8, 5'd0));
    emit(encode_j(21'h1ffffc, 5'd11));
  endtask

  initial begin
    begin_test(1);
    seed_regs();
    random_reg_imm(60);
    run_program();
    begin_test(2);
    seed_regs();
    random_reg_reg(60);
    run_program();
    begin_test(3);
    emit(encode_i(12'd7, 5'd0, 3'd0, 5'd1, OP_IMM));
    emit(encode_i(12'd5, 5'd1, 3'd0, 5'd0, OP_IMM));
    emit(encode_u(20'hfffff, 5'd0, OP_LUI));
    emit(encode_r(FUNCT7_BASE, 5'd1, 5'd1, 3'd0, 5'd0));
    emit(encode_r(FUNCT7_BASE, 5'd0, 5'd0, 3'd0, 5'd2));
    emit(encode_r(FUNCT7_BASE, 5'd0, 5'd1, 3'd0, 5'd3));
    run_program();
    begin_test(4);
    branch_program();
    run_program();
    begin_test(5);
    jump_program();
    run_program();
    begin_test(6);
    emit(encode_i(12'd1, 5'd0, 3'd0, 5'd1, OP_IMM));
    emit(encode_i(12'd0, 5'd0, 3'd0, 5'd0, OP_MISC_MEM));
    // Unknown opcode aimed at x1
    emit(32'h0000_00ff);
    emit(encode_i(12'd1, 5'd1, 3'd0, 5'd2, OP_IMM));
    run_program();
    @(negedge clk);
    $display("tests passed %0d, failed %0d, mismatches %0d", passed, failed, errors);
    if (passed + failed != NUM_TESTS) begin
      $display("not every test reached its halt report");
    end
    if ((failed == 0) && (errors == 0) && (passed == NUM_TESTS)) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_pc_unit.sv
rv_core.sv
rv_core_props.sv
rv_checker.sv
tb_rv_core.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_rv_core
FILELIST = tb.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(filter %.sv,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
